/* include/rv_core_defines.svh */
`ifndef RV_CORE_DEFINES_SVH
`define RV_CORE_DEFINES_SVH

// RV32I base integer register file geometry
`define XLEN       32
`define REG_COUNT  32
`define REG_ADDR_W 5

`endif

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the core testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
    --top-module rv_core_tb \
    -f sources.f \
    -o rv_core_sim

./obj_dir/rv_core_sim | tee "$LOG"

if grep -qx '>>> PASS' "$LOG"; then
    exit 0
fi
echo "Simulation did not report a pass, see $LOG"
exit 1

/* sources.f */
+incdir+include
verilog/rv_isa_pkg.sv
verilog/rv_pipe_pkg.sv
verilog/rv_reg_file.sv
verilog/rv_decode.sv
verilog/rv_execute.sv
verilog/rv_result.sv
verilog/rv_core_top.sv
tests/rv_core_props.sv
tests/rv_core_tb.sv

/* tests/rv_core_patterns.txt */
// instruction  flags_rd  expected_data
// flags_rd bit 8 set issues with no idle cycle before, bits 4:0 hold the expected rd
00500093 001 00000005
FFD00113 002 FFFFFFFD
00112193 003 00000001
00113213 004 00000000
FFF0C293 005 FFFFFFFA
0F00E313 006 000000F5
0FF17393 007 000000FD
00409413 008 00000050
40115493 009 FFFFFFFE
01C15593 00B 0000000F
80000637 00C 80000000
002086B3 00D 00000002
40110733 00E FFFFFFF8
401657B3 00F FC000000
0020B833 010 00000001
001628B3 011 00000001
00165933 012 04000000
001099B3 013 000000A0
0062EA33 014 FFFFFFFF
0070CAB3 015 000000F8
00617B33 016 000000F5
// forwarding at distance one, two and three
06400B93 017 00000064
001B8C13 118 00000065
017C0CB3 119 000000C9
417C8D33 11A 00000065
01AC0DB3 11B 000000CA
002D1E13 11C 00000194
// x0 writes and an unknown opcode
00708013 100 00000000
00100EB3 11D 00000005
00000F7F 01E 00000000
001F0FB3 11F 00000005
12368513 00A 00000125

/* tests/rv_core_props.sv */
`timescale 1ns/1ps
`include "rv_core_defines.svh"

module rvCoreProps (
    input logic                   clk,
    input logic                   rstN,
    input logic                   instrValid,
    input logic                   retireValid,
    input logic [`REG_ADDR_W-1:0] retireRd,
    input logic [`XLEN-1:0]       retireData
);

    // Fixed three-edge pipeline latency, both ways
    property issueToRetire;
        @(posedge clk) disable iff (!rstN) instrValid |-> ##3 retireValid;
    endproperty

    property retireFromIssue;
        @(posedge clk) disable iff (!rstN) retireValid |-> $past(instrValid, 3);
    endproperty

    property quietInReset;
        @(posedge clk) !rstN |=> !retireValid;
    endproperty

    // x0 destinations retire empty
    property x0RetiresZero;
        @(posedge clk) disable iff (!rstN)
            retireValid && retireRd == '0 |-> retireData == '0;
    endproperty

    assert property (issueToRetire) else $error("Instruction did not retire three edges later");
    assert property (retireFromIssue) else $error("Retire without an instruction three edges back");
    assert property (quietInReset) else $error("retireValid high during reset");
    assert property (x0RetiresZero) else $error("Retire to x0 with nonzero data");

endmodule

bind rv_core_top rvCoreProps props_i (
    .clk         (clk),
    .rstN        (rstN),
    .instrValid  (instrValid),
    .retireValid (retireValid),
    .retireRd    (retireRd),
    .retireData  (retireData)
);

/* tests/rv_core_tb.sv */
`timescale 1ns/1ps
`include "rv_core_defines.svh"

module rv_core_tb
    import rv_isa_pkg::*;
();

    localparam int MAX_PATTERNS   = 64;
    localparam int PAT_WORDS      = 3 * MAX_PATTERNS;
    localparam int RETIRE_TIMEOUT = 500;  // Cycles after the last issue
    localparam int ENTRY_W        = `REG_ADDR_W + `XLEN;

    logic                   clk;
    logic                   rstN;
    logic                   instrValid;
    rvInstrT                instr;
    logic                   retireValid;
    logic [`REG_ADDR_W-1:0] retireRd;
    logic [`XLEN-1:0]       retireData;
    logic [`XLEN-1:0]       a0;

    logic [31:0]        patMem [PAT_WORDS];  // Word, flags with rd, data
    int                 numPatterns;
    int                 errors;
    int                 testsRun;
    logic [31:0]        lfsrState;
    rvInstrT            issueHist [3];  // Bus words of the last three cycles
    rvInstrT            issueQ [$];
    logic [ENTRY_W-1:0] retireQ [$];

    rv_core_top dut_i (
        .clk         (clk),
        .rstN        (rstN),
        .instrValid  (instrValid),
        .instr       (instr),
        .retireValid (retireValid),
        .retireRd    (retireRd),
        .retireData  (retireData),
        .a0          (a0)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Issue and retire seen mid-cycle
    always @(negedge clk) begin
        if (retireValid) begin
            retireQ.push_back({retireRd, retireData});
            issueQ.push_back(issueHist[2]);  // Word issued three edges before
        end
        issueHist[2] = issueHist[1];
        issueHist[1] = issueHist[0];
        issueHist[0] = instrValid ? instr : 'x;
    end

    // Fibonacci taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic takeRandomBits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int k = 0; k < n; k++) begin
            lfsrState = lfsrNext(lfsrState);
            bits      = {bits[30:0], lfsrState[0]};
        end
    endtask

    task automatic waitNegedges(input int n);
        for (int k = 0; k < n; k++) begin
            @(negedge clk);
        end
    endtask

    task automatic waitRetires(input int count, output bit ok);
        int cycles;
        cycles = 0;
        while (retireQ.size() < count && cycles < RETIRE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        ok = retireQ.size() >= count;
    endtask

    task automatic sendPatterns();
        logic [31:0] gapBits;
        for (int n = 0; n < numPatterns; n++) begin
            if (!patMem[3*n+1][8]) begin  // Flag bit 8 means no gap
                takeRandomBits(2, gapBits);
                for (int k = 0; k < int'(gapBits[1:0]); k++) begin
                    @(posedge clk);
                    instrValid <= 1'b0;
                end
            end
            @(posedge clk);
            instrValid <= 1'b1;
            instr      <= patMem[3*n];
        end
        @(posedge clk);
        instrValid <= 1'b0;
    endtask

    task automatic checkRetire(input int idx,
                               input logic [`REG_ADDR_W-1:0] gotRd,
                               input logic [`XLEN-1:0] gotData,
                               input logic [`REG_ADDR_W-1:0] expRd,
                               input logic [`XLEN-1:0] expData);
        if (gotRd !== expRd || gotData !== expData) begin
            errors++;
            $display("** Error at %0t: pattern %0d retired x%0d = %h, expected x%0d = %h",
                     $time, idx, gotRd, gotData, expRd, expData);
        end
    endtask

    task automatic checkA0(input string what, input logic [`XLEN-1:0] got,
                           input logic [`XLEN-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: a0 %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic checkInstr(input int idx, input rvInstrT got, input rvInstrT exp);
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t: retire %0d belongs to word %h (opcode %h rd x%0d), expected %h",
                     $time, idx, got, got.r.opcode, got.r.rd, exp);
        end
    endtask

    initial begin
        logic [ENTRY_W-1:0] entry;
        logic [`XLEN-1:0]   expA0;
        bit                 ok;
        int                 errBefore;

        rstN        <= 1'b0;
        instrValid  <= 1'b0;
        instr       <= '0;
        errors      = 0;
        testsRun    = 0;
        ok          = 1'b0;
        expA0       = '0;
        lfsrState   = 32'h6007630b;
        numPatterns = 0;
        for (int i = 0; i < PAT_WORDS; i++) begin
            patMem[i] = {16'hdead, i[15:0]};  // Marks words the file leaves empty
        end
        $readmemh("tests/rv_core_patterns.txt", patMem);
        while (numPatterns < MAX_PATTERNS
               && patMem[3*numPatterns] != {16'hdead, 16'(3 * numPatterns)}) begin
            numPatterns++;
        end

        repeat (16) @(posedge clk);
        rstN <= 1'b1;

        // Idle core after reset
        waitNegedges(8);
        errBefore = errors;
        if (retireQ.size() != 0) begin
            errors++;
            $display("Core retired %0d instructions while idle after reset", retireQ.size());
        end
        checkA0("after reset", a0, '0);
        testsRun++;
        $display("Test reset idle: %s", errors == errBefore ? "ok" : "mismatch");

        if (numPatterns == 0) begin
            errors++;
            $display("Pattern file held no instructions");
        end else begin
            sendPatterns();
            waitRetires(numPatterns, ok);
            if (!ok) begin
                errors++;
                $display("Timeout: only %0d of %0d instructions retired",
                         retireQ.size(), numPatterns);
            end else begin
                waitNegedges(4);  // Lets the x10 write land
                if (retireQ.size() != numPatterns) begin
                    errors++;
                    $display("Retired %0d instructions, expected %0d",
                             retireQ.size(), numPatterns);
                end
                for (int n = 0; n < numPatterns; n++) begin
                    errBefore = errors;
                    entry     = retireQ[n];
                    checkInstr(n, issueQ[n], patMem[3*n]);
                    checkRetire(n, entry[ENTRY_W-1:`XLEN], entry[`XLEN-1:0],
                                patMem[3*n+1][`REG_ADDR_W-1:0], patMem[3*n+2]);
                    if (patMem[3*n+1][`REG_ADDR_W-1:0] == 5'd10) begin
                        expA0 = patMem[3*n+2];
                    end
                    testsRun++;
                    $display("Test %0d: %h -> x%0d %s", n, patMem[3*n],
                             patMem[3*n+1][`REG_ADDR_W-1:0],
                             errors == errBefore ? "ok" : "mismatch");
                end
                errBefore = errors;
                checkA0("after last retire", a0, expA0);
                testsRun++;
                $display("Test a0 view: %s", errors == errBefore ? "ok" : "mismatch");
            end
        end

        $display("Summary: %0d tests, %0d errors", testsRun, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* verilog/rv_core_top.sv */
`timescale 1ns/1ps
`include "rv_core_defines.svh"

module rv_core_top
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   instrValid,
    input  rvInstrT                instr,
    output logic                   retireValid,
    output logic [`REG_ADDR_W-1:0] retireRd,
    output logic [`XLEN-1:0]       retireData,
    output logic [`XLEN-1:0]       a0
);

    // Register file ports
    logic [`REG_ADDR_W-1:0] rdAddrA;
    logic [`REG_ADDR_W-1:0] rdAddrB;
    logic [`XLEN-1:0]       rdDataA;
    logic [`XLEN-1:0]       rdDataB;
    logic                   wrEn;
    logic [`REG_ADDR_W-1:0] wrAddr;
    logic [`XLEN-1:0]       wrData;

    // Decode stage
    logic                   decValid;
    logic [`REG_ADDR_W-1:0] decRd;
    logic [`REG_ADDR_W-1:0] decRs1;
    logic [`REG_ADDR_W-1:0] decRs2;
    aluOpT                  decAluOp;
    logic                   decUseImm;
    logic                   decRegWrite;
    logic [`XLEN-1:0]       decRs1Data;
    logic [`XLEN-1:0]       decRs2Data;
    logic [`XLEN-1:0]       decImm;

    // Execute stage
    logic                   exeValid;
    logic [`REG_ADDR_W-1:0] exeRd;
    logic                   exeRegWrite;
    logic [`XLEN-1:0]       exeResult;

    // Writeback stage, also forwarded
    logic                   resValid;
    logic [`REG_ADDR_W-1:0] resRd;
    logic                   resRegWrite;
    logic [`XLEN-1:0]       resData;

    rv_decode decode_i (
        .clk         (clk),
        .rstN        (rstN),
        .instrValid  (instrValid),
        .instr       (instr),
        .rdAddrA     (rdAddrA),
        .rdAddrB     (rdAddrB),
        .rdDataA     (rdDataA),
        .rdDataB     (rdDataB),
        .decValid    (decValid),
        .decRd       (decRd),
        .decRs1      (decRs1),
        .decRs2      (decRs2),
        .decAluOp    (decAluOp),
        .decUseImm   (decUseImm),
        .decRegWrite (decRegWrite),
        .decRs1Data  (decRs1Data),
        .decRs2Data  (decRs2Data),
        .decImm      (decImm)
    );

    rv_execute execute_i (
        .clk         (clk),
        .rstN        (rstN),
        .decValid    (decValid),
        .decRd       (decRd),
        .decRs1      (decRs1),
        .decRs2      (decRs2),
        .decAluOp    (decAluOp),
        .decUseImm   (decUseImm),
        .decRegWrite (decRegWrite),
        .decRs1Data  (decRs1Data),
        .decRs2Data  (decRs2Data),
        .decImm      (decImm),
        .resValid    (resValid),
        .resRd       (resRd),
        .resRegWrite (resRegWrite),
        .resData     (resData),
        .exeValid    (exeValid),
        .exeRd       (exeRd),
        .exeRegWrite (exeRegWrite),
        .exeResult   (exeResult)
    );

    rv_result result_i (
        .clk         (clk),
        .rstN        (rstN),
        .exeValid    (exeValid),
        .exeRd       (exeRd),
        .exeRegWrite (exeRegWrite),
        .exeResult   (exeResult),
        .resValid    (resValid),
        .resRd       (resRd),
        .resRegWrite (resRegWrite),
        .resData     (resData),
        .wrEn        (wrEn),
        .wrAddr      (wrAddr),
        .wrData      (wrData),
        .retireValid (retireValid),
        .retireRd    (retireRd),
        .retireData  (retireData)
    );

    rv_reg_file regFile_i (
        .clk     (clk),
        .rstN    (rstN),
        .rdAddrA (rdAddrA),
        .rdAddrB (rdAddrB),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB),
        .wrEn    (wrEn),
        .wrAddr  (wrAddr),
        .wrData  (wrData),
        .a0      (a0)
    );

endmodule

/* verilog/rv_decode.sv */
`timescale 1ns/1ps
`include "rv_core_defines.svh"

module rv_decode
    import rv_isa_pkg::*;
    import rv_pipe_pkg::*;
(
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   instrValid,
    input  rvInstrT                instr,
    output logic [`REG_ADDR_W-1:0] rdAddrA,
    output logic [`REG_ADDR_W-1:0] rdAddrB,
    input  logic [`XLEN-1:0]       rdDataA,
    input  logic [`XLEN-1:0]       rdDataB,
    output logic                   decValid,
    output logic [`REG_ADDR_W-1:0] decRd,
    output logic [`REG_ADDR_W-1:0] decRs1,
    output logic [`REG_ADDR_W-1:0] decRs2,
    output aluOpT                  decAluOp,
    output logic                   decUseImm,
    output logic                   decRegWrite,
    output logic [`XLEN-1:0]       decRs1Data,
    output logic [`XLEN-1:0]       decRs2Data,
    output logic [`XLEN-1:0]       decImm
);

    aluOpT            aluOp;
    logic             useImm;
    logic             legal;
    logic             immShift;
    logic [6:0]       shiftKind;  // imm12[11:5] on immediate shifts
    logic [`XLEN-1:0] imm;

    function automatic aluOpT aluFromFunct3(input funct3T f3, input logic alt);
        case (f3)
            F3_ADD_SUB: return alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     return ALU_SLL;
            F3_SLT:     return ALU_SLT;
            F3_SLTU:    return ALU_SLTU;
            F3_XOR:     return ALU_XOR;
            F3_SRL_SRA: return alt ? ALU_SRA : ALU_SRL;
            F3_OR:      return ALU_OR;
            default:    return ALU_AND;
        endcase
    endfunction

    assign rdAddrA   = instr.r.rs1;
    assign rdAddrB   = instr.r.rs2;
    assign immShift  = instr.i.funct3 == F3_SLL || instr.i.funct3 == F3_SRL_SRA;
    assign shiftKind = instr.i.imm12[11:5];

    always_comb begin
        aluOp  = ALU_ADD;
        useImm = 1'b0;
        legal  = 1'b0;
        imm    = '0;
        case (instr.r.opcode)
            OP: begin
                aluOp = aluFromFunct3(instr.r.funct3, instr.r.funct7 == F7_ALT);
                legal = instr.r.funct7 == F7_BASE
                     || (instr.r.funct7 == F7_ALT
                         && (instr.r.funct3 == F3_ADD_SUB || instr.r.funct3 == F3_SRL_SRA));
            end
            OP_IMM: begin
                useImm = 1'b1;
                imm    = {{(`XLEN-12){instr.i.imm12[11]}}, instr.i.imm12};
                aluOp  = aluFromFunct3(instr.i.funct3, immShift && shiftKind == F7_ALT);
                // Shifts only accept the two shamt encodings
                legal  = !immShift || shiftKind == F7_BASE
                      || (instr.i.funct3 == F3_SRL_SRA && shiftKind == F7_ALT);
            end
            LUI: begin
                aluOp  = ALU_PASSB;
                useImm = 1'b1;
                legal  = 1'b1;
                imm    = {instr.i.imm12, instr.i.rs1, instr.i.funct3, {12{1'b0}}};
            end
            default: legal = 1'b0;  // Retires without a write
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            decValid    <= 1'b0;
            decRegWrite <= 1'b0;
        end else begin
            decValid    <= instrValid;
            decRegWrite <= instrValid && legal;
        end
    end

    // Payload only moves with a new instruction
    always_ff @(posedge clk) begin
        if (instrValid) begin
            decRd      <= instr.r.rd;
            decRs1     <= instr.r.rs1;
            decRs2     <= instr.r.rs2;
            decAluOp   <= aluOp;
            decUseImm  <= useImm;
            decRs1Data <= rdDataA;
            decRs2Data <= rdDataB;
            decImm     <= imm;
        end
    end

endmodule

/* verilog/rv_execute.sv */
`timescale 1ns/1ps
`include "rv_core_defines.svh"

module rv_execute
    import rv_pipe_pkg::*;
(
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   decValid,
    input  logic [`REG_ADDR_W-1:0] decRd,
    input  logic [`REG_ADDR_W-1:0] decRs1,
    input  logic [`REG_ADDR_W-1:0] decRs2,
    input  aluOpT                  decAluOp,
    input  logic                   decUseImm,
    input  logic                   decRegWrite,
    input  logic [`XLEN-1:0]       decRs1Data,
    input  logic [`XLEN-1:0]       decRs2Data,
    input  logic [`XLEN-1:0]       decImm,
    input  logic                   resValid,
    input  logic [`REG_ADDR_W-1:0] resRd,
    input  logic                   resRegWrite,
    input  logic [`XLEN-1:0]       resData,
    output logic                   exeValid,
    output logic [`REG_ADDR_W-1:0] exeRd,
    output logic                   exeRegWrite,
    output logic [`XLEN-1:0]       exeResult
);

    localparam int SHAMT_W = $clog2(`XLEN);

    fwdSelT             selA;
    fwdSelT             selB;
    logic [`XLEN-1:0]   opA;
    logic [`XLEN-1:0]   rs2Val;
    logic [`XLEN-1:0]   opB;
    logic [`XLEN-1:0]   aluOut;
    logic [SHAMT_W-1:0] shamt;

    // Youngest matching producer wins
    function automatic fwdSelT fwdSel(input logic [`REG_ADDR_W-1:0] rs);
        if (exeValid && exeRegWrite && exeRd != '0 && exeRd == rs) begin
            return FWD_EXEC;
        end
        if (resValid && resRegWrite && resRd != '0 && resRd == rs) begin
            return FWD_RESULT;
        end
        return FWD_REG;
    endfunction

    function automatic logic [`XLEN-1:0] fwdMux(input fwdSelT sel, input logic [`XLEN-1:0] regVal);
        case (sel)
            FWD_EXEC:   return exeResult;
            FWD_RESULT: return resData;
            default:    return regVal;
        endcase
    endfunction

    always_comb begin
        selA   = fwdSel(decRs1);
        selB   = fwdSel(decRs2);
        opA    = fwdMux(selA, decRs1Data);
        rs2Val = fwdMux(selB, decRs2Data);
        opB    = decUseImm ? decImm : rs2Val;
    end

    assign shamt = opB[SHAMT_W-1:0];

    always_comb begin
        case (decAluOp)
            ALU_ADD:  aluOut = opA + opB;
            ALU_SUB:  aluOut = opA - opB;
            ALU_AND:  aluOut = opA & opB;
            ALU_OR:   aluOut = opA | opB;
            ALU_XOR:  aluOut = opA ^ opB;
            ALU_SLT:  aluOut = {{(`XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
            ALU_SLTU: aluOut = {{(`XLEN-1){1'b0}}, opA < opB};
            ALU_SLL:  aluOut = opA << shamt;
            ALU_SRL:  aluOut = opA >> shamt;
            ALU_SRA:  aluOut = $signed(opA) >>> shamt;
            default:  aluOut = opB;  // PASSB
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            exeValid    <= 1'b0;
            exeRegWrite <= 1'b0;
            exeRd       <= '0;
        end else begin
            exeValid    <= decValid;
            exeRegWrite <= decValid && decRegWrite;
            exeRd       <= decRd;
        end
    end

    // Zero for non-writing instructions and x0
    always_ff @(posedge clk) begin
        exeResult <= (decValid && decRegWrite && decRd != '0) ? aluOut : '0;
    end

endmodule

/* verilog/rv_isa_pkg.sv */
package rv_isa_pkg;

    // Major opcodes handled by the core
    typedef enum logic [6:0] {
        OP     = 7'b0110011,  // Register-register ALU
        OP_IMM = 7'b0010011,  // Register-immediate ALU
        LUI    = 7'b0110111
    } opcodeT;

    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SRL_SRA = 3'b101,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } funct3T;

    // Also found in imm12[11:5] of the immediate shifts
    typedef enum logic [6:0] {
        F7_BASE = 7'b0000000,
        F7_ALT  = 7'b0100000  // sub and sra
    } funct7T;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        funct3T     funct3;
        logic [4:0] rd;
        opcodeT     opcode;
    } rTypeT;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        funct3T      funct3;
        logic [4:0]  rd;
        opcodeT      opcode;
    } iTypeT;

    // Same word, two decodings
    typedef union packed {
        rTypeT r;
        iTypeT i;
    } rvInstrT;

endpackage

/* verilog/rv_pipe_pkg.sv */
package rv_pipe_pkg;

    // Operation carried from decode into execute
    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_AND   = 4'd2,
        ALU_OR    = 4'd3,
        ALU_XOR   = 4'd4,
        ALU_SLT   = 4'd5,
        ALU_SLTU  = 4'd6,
        ALU_SLL   = 4'd7,
        ALU_SRL   = 4'd8,
        ALU_SRA   = 4'd9,
        ALU_PASSB = 4'd10  // lui, operand B straight through
    } aluOpT;

    // Where an execute operand comes from
    typedef enum logic [1:0] {
        FWD_REG    = 2'd0,  // Value read in decode
        FWD_EXEC   = 2'd1,  // Previous instruction, execute register
        FWD_RESULT = 2'd2   // Two back, writeback register
    } fwdSelT;

endpackage

/* verilog/rv_reg_file.sv */
`timescale 1ns/1ps
`include "rv_core_defines.svh"

module rv_reg_file (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic [`REG_ADDR_W-1:0] rdAddrA,
    input  logic [`REG_ADDR_W-1:0] rdAddrB,
    output logic [`XLEN-1:0]       rdDataA,
    output logic [`XLEN-1:0]       rdDataB,
    input  logic                   wrEn,
    input  logic [`REG_ADDR_W-1:0] wrAddr,
    input  logic [`XLEN-1:0]       wrData,
    output logic [`XLEN-1:0]       a0
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    // Write-first read with x0 tied to zero
    function automatic logic [`XLEN-1:0] readPort(input logic [`REG_ADDR_W-1:0] addr,
                                                  input logic [`XLEN-1:0] stored);
        if (addr == '0) begin
            return '0;
        end
        if (wrEn && wrAddr == addr) begin
            return wrData;
        end
        return stored;
    endfunction

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrAddr != '0) begin  // x0 never written
            regs[wrAddr] <= wrData;
        end
    end

    assign rdDataA = readPort(rdAddrA, regs[rdAddrA]);
    assign rdDataB = readPort(rdAddrB, regs[rdAddrB]);
    assign a0      = regs[10];

endmodule

/* verilog/rv_result.sv */
`timescale 1ns/1ps
`include "rv_core_defines.svh"

module rv_result (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   exeValid,
    input  logic [`REG_ADDR_W-1:0] exeRd,
    input  logic                   exeRegWrite,
    input  logic [`XLEN-1:0]       exeResult,
    output logic                   resValid,
    output logic [`REG_ADDR_W-1:0] resRd,
    output logic                   resRegWrite,
    output logic [`XLEN-1:0]       resData,
    output logic                   wrEn,
    output logic [`REG_ADDR_W-1:0] wrAddr,
    output logic [`XLEN-1:0]       wrData,
    output logic                   retireValid,
    output logic [`REG_ADDR_W-1:0] retireRd,
    output logic [`XLEN-1:0]       retireData
);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            resValid    <= 1'b0;
            resRegWrite <= 1'b0;
            resRd       <= '0;
        end else begin
            resValid    <= exeValid;
            resRegWrite <= exeValid && exeRegWrite;
            resRd       <= exeRd;
        end
    end

    always_ff @(posedge clk) begin
        resData <= exeResult;
    end

    // Register file is written in the retire cycle
    assign wrEn   = resValid && resRegWrite && resRd != '0;
    assign wrAddr = resRd;
    assign wrData = resData;

    assign retireValid = resValid;
    assign retireRd    = resRd;
    assign retireData  = resData;

endmodule
